/* decodeStage.f */
+incdir+hdl
hdl/decodePkg.sv
hdl/aluDecoder.sv
hdl/memDecoder.sv
hdl/sysDecoder.sv
hdl/immGen.sv
hdl/decodeCtrl.sv
hdl/decodeStage.sv
test/tbClock.sv
test/tbDecodeStage.sv

/* test/tbDecodeStage.sv */
/*
 * Testbench of the decode stage: random instruction stream under random back-pressure.
 * A reference decode model fills a queue of expected bundles; assertions check each output.
 */
`timescale 1ns/1ns
`include "decode_consts.svh"

module tbDecodeStage import decodePkg::*; ();

	localparam int numInsts = 400;
	localparam int timeoutCycles = numInsts * 8 + 200;

	logic clk;
	logic reset;
	logic inValid;
	logic inReady;
	logic [`INST_WIDTH-1:0] inst;
	logic outValid;
	logic outReady;
	decodedT decoded;

	decodedT expQ[$];
	decodedT expHead;
	int expCount;
	int sent;

	tbClock clkGen (.clk(clk), .reset(reset));

	decodeStage DUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inst(inst),
		.outValid(outValid),
		.outReady(outReady),
		.decoded(decoded)
	);

	task automatic stopRun(string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "Run stopped at the first failing check");
	endtask

	task automatic valueError(string name, logic [31:0] expVal, logic [31:0] actVal);
		stopRun($sformatf("** Error: %s expected 0x%h actual 0x%h", name, expVal, actVal));
	endtask

	// Expected bundle built field by field from the RV32 encoding rules
	function automatic decodedT expectDecode(logic [31:0] word);
		decodedT d;
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		logic isReg;
		logic legal;
		d = '0;
		op = word[6:0];
		f3 = word[14:12];
		f7 = word[31:25];
		isReg = (op == opRegArith);
		case (op)
			opRegArith, opImmArith: begin
				case (f3)
					3'b000: legal = !isReg || f7 == `F7_BASE || f7 == `F7_ALT;
					3'b001: legal = (f7 == `F7_BASE);
					3'b101: legal = (f7 == `F7_BASE) || (f7 == `F7_ALT);
					default: legal = 1'b1;
				endcase
				if (legal) begin
					case (f3)
						3'b000: d.alu.aluOp = (isReg && f7 == `F7_ALT) ? aluSub : aluAdd;
						3'b001: d.alu.aluOp = aluSll;
						3'b010: d.alu.aluOp = aluCmp;
						3'b011: d.alu.aluOp = aluCmpu;
						3'b100: d.alu.aluOp = aluXor;
						3'b101: d.alu.aluOp = (f7 == `F7_ALT) ? aluSra : aluSrl;
						3'b110: d.alu.aluOp = aluOr;
						default: d.alu.aluOp = aluAnd;
					endcase
					d.alu.srcBImm = !isReg;
					d.alu.regWrite = 1'b1;
					d.alu.wbSel = wbAluResult;
				end
			end
			opLoad: begin
				if (f3 != 3'b011 && f3 < 3'b110) begin
					d.alu.srcBImm = 1'b1;
					d.alu.regWrite = 1'b1;
					d.alu.wbSel = wbMemData;
					d.mem.memValid = 1'b1;
					d.mem.wmask = `WMASK_WORD;
					case (f3)
						3'b000: d.mem.memKind = memByte;
						3'b001: d.mem.memKind = memHalf;
						3'b010: d.mem.memKind = memWord;
						3'b100: d.mem.memKind = memByteU;
						default: d.mem.memKind = memHalfU;
					endcase
				end
			end
			opStore: begin
				if (f3 < 3'b011) begin
					d.alu.srcBImm = 1'b1;
					d.mem.memValid = 1'b1;
					d.mem.memWrite = 1'b1;
					d.mem.wmask = (f3 == 3'b000) ? `WMASK_BYTE :
						(f3 == 3'b001) ? `WMASK_HALF : `WMASK_WORD;
				end
			end
			opBranch: begin
				case (f3)
					3'b000, 3'b001: d.alu.aluOp = aluSub;
					3'b100, 3'b101: d.alu.aluOp = aluCmp;
					3'b110, 3'b111: d.alu.aluOp = aluCmpu;
					default: d.alu.aluOp = aluAdd;
				endcase
			end
			opLui: begin
				d.alu.regWrite = 1'b1;
				d.alu.wbSel = wbImm;
			end
			opAuipc, opJal: begin
				d.alu.srcAPc = 1'b1;
				d.alu.srcBImm = 1'b1;
				d.alu.regWrite = 1'b1;
				d.alu.wbSel = (op == opJal) ? wbPcPlus4 : wbAluResult;
			end
			opJalr: begin
				d.alu.srcBImm = 1'b1;
				d.alu.regWrite = 1'b1;
				d.alu.wbSel = wbPcPlus4;
			end
			opSystem: begin
				if (f3 == 3'b001 || f3 == 3'b010) begin
					d.alu.regWrite = 1'b1;
					d.alu.wbSel = wbCsr;
					d.sys.csrWrite = 1'b1;
					d.sys.csrSrc = f3[1] ? csrRs1Or : csrRs1;
				end else if (f3 == 3'b000 && word[31:20] == `F12_ECALL) begin
					d.sys.trap = 1'b1;
					d.sys.cause = `MECALL_CAUSE;
					d.sys.csrSrc = csrPc;
				end
			end
			default: d = '0;
		endcase
		// Immediate depends on the opcode alone, sign taken from bit 31
		case (op)
			opImmArith, opLoad, opJalr: d.imm = 32'($signed(word[31:20]));
			opStore: begin
				d.immType = immS;
				d.imm = 32'($signed({word[31:25], word[11:7]}));
			end
			opBranch: begin
				d.immType = immB;
				d.imm = 32'($signed({word[31], word[7], word[30:25], word[11:8], 1'b0}));
			end
			opLui, opAuipc: begin
				d.immType = immU;
				d.imm = {word[31:12], 12'h000};
			end
			opJal: begin
				d.immType = immJ;
				d.imm = 32'($signed({word[31], word[19:12], word[20], word[30:21], 1'b0}));
			end
			default: d.imm = '0;
		endcase
		return d;
	endfunction

	// Random register and immediate bits, then opcode and funct codes forced per class
	function automatic logic [31:0] randomInst();
		logic [31:0] w;
		w = $urandom();
		case ($urandom_range(0, 11))
			0: begin
				w[6:0] = opRegArith;
				w[31:25] = ((w[14:12] == 3'b000 || w[14:12] == 3'b101) && w[30]) ?
					`F7_ALT : `F7_BASE;
			end
			1: begin
				w[6:0] = opImmArith;
				if (w[13:12] == 2'b01) begin
					w[31:25] = (w[14] && w[30]) ? `F7_ALT : `F7_BASE;
				end
			end
			2: begin
				w[6:0] = opLoad;
				if (w[14:12] == 3'b011 || w[14:13] == 2'b11) begin
					w[14:12] = {2'b10, w[7]};
				end
			end
			3: begin
				w[6:0] = opStore;
				w[14:12] = {1'b0, (w[13:12] == 2'b11) ? 2'b10 : w[13:12]};
			end
			4: begin
				w[6:0] = opBranch;
				w[13] = w[14] ? w[13] : 1'b0;
			end
			5: w[6:0] = opLui;
			6: w[6:0] = opAuipc;
			7: w[6:0] = opJal;
			8: begin
				w[6:0] = opJalr;
				w[14:12] = 3'b000;
			end
			9: begin
				w[6:0] = opSystem;
				w[14:12] = w[12] ? 3'b001 : 3'b010;
			end
			10: w = {`F12_ECALL, w[19:15], 3'b000, w[11:7], opSystem};
			default: begin
				// Unlisted encodings
				case (w[2:0])
					3'b000: w = 32'h0010_0073;
					3'b001: w = 32'h3020_0073;
					3'b010: w = {7'h01, w[24:15], (w[12] ? 3'b101 : {2'b00, w[13]}),
						w[11:7], opRegArith};
					3'b011: begin
						w[6:0] = opSystem;
						w[14] = 1'b1;
					end
					3'b100: begin
						w[6:0] = opStore;
						w[14] = 1'b1;
					end
					// No listed opcode ends in 2'b00
					default: w[1:0] = 2'b00;
				endcase
			end
		endcase
		return w;
	endfunction

	// Expected queue follows both transfers of every edge
	always @(posedge clk) begin
		if (reset) begin
			expQ.delete();
		end else begin
			if (outValid && outReady && expQ.size() != 0) begin
				void'(expQ.pop_front());
			end
			if (inValid && inReady) begin
				expQ.push_back(expectDecode(inst));
			end
		end
		expCount = expQ.size();
		expHead = (expQ.size() != 0) ? expQ[0] : '0;
	end

	aluFields: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady |-> decoded.alu == expHead.alu)
		else valueError("decoded.alu", $sampled(expHead.alu), $sampled(decoded.alu));
	memFields: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady |-> decoded.mem == expHead.mem)
		else valueError("decoded.mem", $sampled(expHead.mem), $sampled(decoded.mem));
	sysFields: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady |-> decoded.sys == expHead.sys)
		else valueError("decoded.sys", $sampled(expHead.sys), $sampled(decoded.sys));
	immTypeField: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady |-> decoded.immType == expHead.immType)
		else valueError("decoded.immType", $sampled(expHead.immType), $sampled(decoded.immType));
	immValue: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady |-> decoded.imm == expHead.imm)
		else valueError("decoded.imm", $sampled(expHead.imm), $sampled(decoded.imm));

	pendingOnOutput: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady |-> expCount != 0)
		else stopRun("An output transfer happened with no accepted instruction pending");
	nextEdgeOutput: assert property (@(posedge clk) disable iff (reset)
		inValid && inReady |=> outValid)
		else stopRun("An accepted instruction was not on the output after the next edge");
	heldUnderStall: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(decoded))
		else stopRun("The decoded bundle changed or vanished while the output was stalled");
	stallBlocksInput: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |-> !inReady)
		else stopRun("The input was ready while the output was stalled");
	idleAfterReset: assert property (@(posedge clk)
		reset |=> !outValid && inReady)
		else stopRun("The stage was not idle and ready during or right after reset");

	initial begin
		bit fired;
		inValid = 1'b0;
		outReady = 1'b0;
		inst = '0;
		sent = 0;
		void'($urandom(93));
		wait (!reset);
		while (sent < numInsts) begin
			@(posedge clk);
			fired = inValid && inReady;
			if (fired) begin
				sent++;
			end
			#5;
			// Full throughput for the first hundred, random back-pressure after
			outReady = (sent < 100) || ($urandom_range(0, 3) != 0);
			if (fired || !inValid) begin
				inValid = (sent < numInsts) && ((sent < 100) || ($urandom_range(0, 4) != 0));
				inst = randomInst();
			end
		end
		outReady = 1'b1;
		wait (!outValid);
		#10;
		if (expQ.size() != 0) begin
			stopRun("Accepted instructions never came out of the stage");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

	initial begin
		repeat (timeoutCycles) @(posedge clk);
		stopRun("Watchdog expired before all instructions were decoded");
	end

endmodule

/* test/tbClock.sv */
/*
 * Clock and reset source for the decode stage testbench.
 * 100 ns clock, reset high for the first ten rising edges.
 */
`timescale 1ns/1ns

module tbClock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Release lands just after the tenth edge, like any other driven input
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#5 reset = 1'b0;
	end

endmodule

/* hdl/decodeStage.sv */
/*
 * Top level of the RV32E decode stage.
 * Four field decoders feed one registered valid/ready output.
 */
`timescale 1ns/1ns
`include "decode_consts.svh"

module decodeStage import decodePkg::*; (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input logic [`INST_WIDTH-1:0] inst,
	output logic outValid,
	input logic outReady,
	output decodedT decoded
);

	aluCtrlT aluCtrl;
	memCtrlT memCtrl;
	sysCtrlT sysCtrl;
	immTypeE immType;
	logic [`XLEN-1:0] imm;
	decodedT nextDecoded;

	aluDecoder aluDec (.inst(inst), .aluCtrl(aluCtrl));
	memDecoder memDec (.inst(inst), .memCtrl(memCtrl));
	sysDecoder sysDec (.inst(inst), .sysCtrl(sysCtrl));
	immGen immGenInst (.inst(inst), .immType(immType), .imm(imm));

	assign nextDecoded = '{alu: aluCtrl, mem: memCtrl, sys: sysCtrl, immType: immType, imm: imm};

	decodeCtrl ctrl (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.nextDecoded(nextDecoded),
		.outValid(outValid),
		.outReady(outReady),
		.decoded(decoded)
	);

endmodule

/* hdl/decodeCtrl.sv */
/*
 * Valid/ready control and the single-entry output register of the decode stage.
 * Accepts a new bundle whenever the register is empty or drains this cycle.
 */
`timescale 1ns/1ns

module decodeCtrl import decodePkg::*; (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input decodedT nextDecoded,
	output logic outValid,
	input logic outReady,
	output decodedT decoded
);

	logic inFire;

	assign inReady = !outValid || outReady;
	assign inFire = inValid && inReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
		end else if (inFire) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (inFire) begin
			decoded <= nextDecoded;
		end
	end

	// Back-pressure holds the bundle until it is taken
	holdStable: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(decoded));

	// ALU and SYSTEM decoders never both claim an instruction this way
	noTrapWrite: assert property (@(posedge clk) disable iff (reset)
		outValid |-> !(decoded.sys.trap && decoded.alu.regWrite));

	memWriteValid: assert property (@(posedge clk) disable iff (reset)
		outValid && decoded.mem.memWrite |-> decoded.mem.memValid);

endmodule

/* hdl/immGen.sv */
/*
 * Immediate type per opcode and the sign-extended immediate value.
 * Combinational, opcodes without an immediate give immI and zero.
 */
`timescale 1ns/1ns
`include "decode_consts.svh"

module immGen import decodePkg::*; (
	input logic [`INST_WIDTH-1:0] inst,
	output immTypeE immType,
	output logic [`XLEN-1:0] imm
);

	opcodeE opcode;
	logic sign;

	assign opcode = opcodeE'(inst[6:0]);
	assign sign = inst[31];

	always_comb begin
		case (opcode)
			opImmArith, opLoad, opJalr: immType = immI;
			opStore: immType = immS;
			opBranch: immType = immB;
			opLui, opAuipc: immType = immU;
			opJal: immType = immJ;
			default: immType = immI;
		endcase
	end

	always_comb begin
		case (opcode)
			opImmArith, opLoad, opJalr: begin
				imm = {{20{sign}}, inst[31:20]};
			end
			opStore: begin
				imm = {{20{sign}}, inst[31:25], inst[11:7]};
			end
			// Branch and jump offsets are halfword aligned
			opBranch: begin
				imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			opLui, opAuipc: begin
				imm = {inst[31:12], 12'b0};
			end
			opJal: begin
				imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: imm = '0;
		endcase
	end

endmodule

/* hdl/sysDecoder.sv */
/*
 * CSR write controls and the ecall trap for SYSTEM instructions.
 * Combinational; ebreak, mret and other SYSTEM encodings give an idle bundle.
 */
`timescale 1ns/1ns
`include "decode_consts.svh"

module sysDecoder import decodePkg::*; (
	input logic [`INST_WIDTH-1:0] inst,
	output sysCtrlT sysCtrl
);

	opcodeE opcode;
	logic [2:0] funct3;
	logic [11:0] funct12;

	assign opcode = opcodeE'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct12 = inst[31:20];

	always_comb begin
		sysCtrl = '0;
		if (opcode == opSystem) begin
			case (funct3)
				3'b001: begin
					sysCtrl.csrWrite = 1'b1;
					sysCtrl.csrSrc = csrRs1;
				end
				3'b010: begin
					sysCtrl.csrWrite = 1'b1;
					sysCtrl.csrSrc = csrRs1Or;
				end
				3'b000: begin
					// Machine call, mepc takes the PC
					if (funct12 == `F12_ECALL) begin
						sysCtrl.trap = 1'b1;
						sysCtrl.cause = `MECALL_CAUSE;
						sysCtrl.csrSrc = csrPc;
					end
				end
				default: sysCtrl = '0;
			endcase
		end
	end

endmodule

/* hdl/memDecoder.sv */
/*
 * Memory access controls for loads and stores.
 * Combinational, everything outside LOAD and STORE gives an idle bundle.
 */
`timescale 1ns/1ns
`include "decode_consts.svh"

module memDecoder import decodePkg::*; (
	input logic [`INST_WIDTH-1:0] inst,
	output memCtrlT memCtrl
);

	opcodeE opcode;
	logic [2:0] funct3;
	logic loadLegal;
	memKindE loadKind;

	assign opcode = opcodeE'(inst[6:0]);
	assign funct3 = inst[14:12];

	always_comb begin
		loadLegal = 1'b1;
		loadKind = memWord;
		case (funct3)
			3'b000: loadKind = memByte;
			3'b001: loadKind = memHalf;
			3'b010: loadKind = memWord;
			3'b100: loadKind = memByteU;
			3'b101: loadKind = memHalfU;
			default: loadLegal = 1'b0;
		endcase
	end

	always_comb begin
		memCtrl = '0;
		case (opcode)
			opStore: begin
				memCtrl.memValid = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
				memCtrl.memWrite = memCtrl.memValid;
				case (funct3)
					3'b000: memCtrl.wmask = `WMASK_BYTE;
					3'b001: memCtrl.wmask = `WMASK_HALF;
					3'b010: memCtrl.wmask = `WMASK_WORD;
					default: memCtrl.wmask = '0;
				endcase
			end
			opLoad: begin
				// Loads always fetch the full word, memKind trims it later
				if (loadLegal) begin
					memCtrl.memValid = 1'b1;
					memCtrl.wmask = `WMASK_WORD;
					memCtrl.memKind = loadKind;
				end
			end
			default: memCtrl = '0;
		endcase
	end

endmodule

/* hdl/aluDecoder.sv */
/*
 * ALU operation, operand sources and register write-back control.
 * Combinational, reads only the instruction word.
 */
`timescale 1ns/1ns
`include "decode_consts.svh"

module aluDecoder import decodePkg::*; (
	input logic [`INST_WIDTH-1:0] inst,
	output aluCtrlT aluCtrl
);

	opcodeE opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic isImm;
	aluOpE arithOp;
	logic arithLegal;

	assign opcode = opcodeE'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign isImm = (opcode == opImmArith);

	// funct3 decode shared by register and immediate arithmetic
	always_comb begin
		arithOp = aluAdd;
		arithLegal = 1'b1;
		case (funct3)
			3'b000: begin
				// sub exists only in register form
				if (!isImm) begin
					if (funct7 == `F7_ALT) begin
						arithOp = aluSub;
					end else if (funct7 != `F7_BASE) begin
						arithLegal = 1'b0;
					end
				end
			end
			3'b001: begin
				arithOp = aluSll;
				arithLegal = (funct7 == `F7_BASE);
			end
			3'b010: arithOp = aluCmp;
			3'b011: arithOp = aluCmpu;
			3'b100: arithOp = aluXor;
			3'b101: begin
				arithOp = (funct7 == `F7_ALT) ? aluSra : aluSrl;
				arithLegal = (funct7 == `F7_ALT) || (funct7 == `F7_BASE);
			end
			3'b110: arithOp = aluOr;
			3'b111: arithOp = aluAnd;
		endcase
	end

	always_comb begin
		aluCtrl = '0;
		case (opcode)
			opRegArith, opImmArith: begin
				if (arithLegal) begin
					aluCtrl.aluOp = arithOp;
					aluCtrl.srcBImm = isImm;
					aluCtrl.regWrite = 1'b1;
					aluCtrl.wbSel = wbAluResult;
				end
			end
			opBranch: begin
				// Compare only, branch target comes from the immediate path
				case (funct3)
					3'b000, 3'b001: aluCtrl.aluOp = aluSub;
					3'b100, 3'b101: aluCtrl.aluOp = aluCmp;
					3'b110, 3'b111: aluCtrl.aluOp = aluCmpu;
					default: aluCtrl = '0;
				endcase
			end
			opStore: begin
				if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010) begin
					aluCtrl.aluOp = aluAdd;
					aluCtrl.srcBImm = 1'b1;
				end
			end
			opLoad: begin
				if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
					aluCtrl.aluOp = aluAdd;
					aluCtrl.srcBImm = 1'b1;
					aluCtrl.regWrite = 1'b1;
					aluCtrl.wbSel = wbMemData;
				end
			end
			opAuipc: begin
				aluCtrl.srcAPc = 1'b1;
				aluCtrl.srcBImm = 1'b1;
				aluCtrl.regWrite = 1'b1;
				aluCtrl.wbSel = wbAluResult;
			end
			opLui: begin
				aluCtrl.regWrite = 1'b1;
				aluCtrl.wbSel = wbImm;
			end
			opJal: begin
				aluCtrl.srcAPc = 1'b1;
				aluCtrl.srcBImm = 1'b1;
				aluCtrl.regWrite = 1'b1;
				aluCtrl.wbSel = wbPcPlus4;
			end
			opJalr: begin
				aluCtrl.srcBImm = 1'b1;
				aluCtrl.regWrite = 1'b1;
				aluCtrl.wbSel = wbPcPlus4;
			end
			opSystem: begin
				// csrrw and csrrs return the old CSR value
				if (funct3 == 3'b001 || funct3 == 3'b010) begin
					aluCtrl.regWrite = 1'b1;
					aluCtrl.wbSel = wbCsr;
				end
			end
			default: aluCtrl = '0;
		endcase
	end

endmodule

/* hdl/decodePkg.sv */
/*
 * Types shared by the decode stage: opcodes, control encodings and the decoded bundle.
 * Modules take these by importing the package in their header.
 */
`include "decode_consts.svh"

package decodePkg;

	// Major opcodes of RV32E
	typedef enum logic [6:0] {
		opSystem = 7'b1110011,
		opImmArith = 7'b0010011,
		opRegArith = 7'b0110011,
		opStore = 7'b0100011,
		opLoad = 7'b0000011,
		opBranch = 7'b1100011,
		opAuipc = 7'b0010111,
		opLui = 7'b0110111,
		opJal = 7'b1101111,
		opJalr = 7'b1100111
	} opcodeE;

	// ALU operations, encodings match the execute stage
	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluCmp = 4'd3,
		aluXor = 4'd4,
		aluCmpu = 4'd5,
		aluOr = 4'd6,
		aluSra = 4'd7,
		aluSrl = 4'd8,
		aluSll = 4'd9
	} aluOpE;

	typedef enum logic [2:0] {
		memByte = 3'd0,
		memHalf = 3'd1,
		memWord = 3'd2,
		memByteU = 3'd3,
		memHalfU = 3'd4
	} memKindE;

	// Register write-back source
	typedef enum logic [2:0] {
		wbAluResult = 3'd0,
		wbImm = 3'd1,
		wbPcPlus4 = 3'd2,
		wbMemData = 3'd3,
		wbCsr = 3'd4
	} wbSelE;

	typedef enum logic [1:0] {
		csrRs1 = 2'd0,
		csrRs1Or = 2'd1,
		csrPc = 2'd2
	} csrSrcE;

	typedef enum logic [2:0] {
		immI = 3'd0,
		immU = 3'd1,
		immJ = 3'd2,
		immS = 3'd3,
		immB = 3'd4
	} immTypeE;

	typedef struct packed {
		aluOpE aluOp;
		logic srcAPc;
		logic srcBImm;
		logic regWrite;
		wbSelE wbSel;
	} aluCtrlT;

	typedef struct packed {
		logic memValid;
		logic memWrite;
		logic [`WMASK_WIDTH-1:0] wmask;
		memKindE memKind;
	} memCtrlT;

	typedef struct packed {
		logic csrWrite;
		csrSrcE csrSrc;
		logic trap;
		logic [`CAUSE_WIDTH-1:0] cause;
	} sysCtrlT;

	// Full bundle handed to the execute stage
	typedef struct packed {
		aluCtrlT alu;
		memCtrlT mem;
		sysCtrlT sys;
		immTypeE immType;
		logic [`XLEN-1:0] imm;
	} decodedT;

endpackage

/* hdl/decode_consts.svh */
/*
 * Widths and encoding constants for the RV32E decode stage.
 * Included by the package and by every decoder that compares instruction fields.
 */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Datapath widths
`define INST_WIDTH 32
`define XLEN 32

// Trap cause
`define CAUSE_WIDTH 8
`define MECALL_CAUSE 8'h0B

// Store byte masks
`define WMASK_WIDTH 8
`define WMASK_BYTE 8'h01
`define WMASK_HALF 8'h03
`define WMASK_WORD 8'h0F

// funct7 picks add/sub and srl/sra
`define F7_BASE 7'h00
`define F7_ALT 7'h20

// funct12 of ecall under SYSTEM with funct3 zero
`define F12_ECALL 12'h000

`endif
